// ==== src.f ====
+incdir+test
verilog/rv_core_pkg.sv
verilog/rv_decoder.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_core_top.sv
test/rv_core_chk.sv
test/rv_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rv_core_tb -f src.f -o rv_core_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/rv_core_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
echo "pass line missing from simulation output"
exit 1

// ==== test/rv_core_model.svh ====
`ifndef RV_CORE_MODEL_SVH
`define RV_CORE_MODEL_SVH

// ==============================
// reference model state
// ==============================

logic [63:0] m_regs [0:31];
logic [63:0] m_pc;

// expected outcome of the instruction under test
logic        exp_we;
logic [4:0]  exp_rd;
logic [63:0] exp_data;
logic        exp_illegal;
logic [63:0] exp_next_pc;

// integer semantics, alt picks sub and sra
function automatic logic [63:0] model_arith(input logic [2:0] f3, input logic alt,
                                            input logic word, input logic [63:0] a,
                                            input logic [63:0] b);
  logic [63:0] r;
  logic [31:0] w;
  r = 64'd0;
  w = 32'd0;
  if (word) begin
    case (f3)
      3'd0: w = alt ? (a[31:0] - b[31:0]) : (a[31:0] + b[31:0]);
      3'd1: w = a[31:0] << b[4:0];
      3'd5: begin
        if (alt) begin
          w = $signed(a[31:0]) >>> b[4:0];
        end else begin
          w = a[31:0] >> b[4:0];
        end
      end
      default: w = 32'd0;
    endcase
    r = {{32{w[31]}}, w};
  end else begin
    case (f3)
      3'd0: r = alt ? (a - b) : (a + b);
      3'd1: r = a << b[5:0];
      3'd2: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      3'd3: r = (a < b) ? 64'd1 : 64'd0;
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) begin
          r = $signed(a) >>> b[5:0];
        end else begin
          r = a >> b[5:0];
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
  end
  return r;
endfunction

// expected writeback, illegal flag and next pc for one instruction
task automatic model_eval(input logic [31:0] inst);
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [63:0] a;
  logic [63:0] b;
  logic [63:0] imm_i;
  logic [63:0] imm_u;
  logic [63:0] imm_j;
  logic [63:0] imm_b;
  logic        legal;
  logic        taken;
  f3    = inst[14:12];
  f7    = inst[31:25];
  a     = m_regs[inst[19:15]];
  b     = m_regs[inst[24:20]];
  imm_i = {{52{inst[31]}}, inst[31:20]};
  imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  exp_rd      = inst[11:7];
  exp_we      = 1'b1;
  exp_data    = 64'd0;
  exp_next_pc = m_pc + 64'd4;
  taken       = 1'b0;
  case (inst[6:0])
    OPC_OP: begin
      legal    = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      exp_data = model_arith(f3, f7[5], 1'b0, a, b);
    end
    OPC_OP_IMM: begin
      legal = 1'b1;
      if (f3 == 3'd1) begin
        legal = (inst[31:26] == 6'h00);
      end else if (f3 == 3'd5) begin
        legal = (inst[31:26] == 6'h00) || (inst[31:26] == 6'h10);
      end
      exp_data = model_arith(f3, (f3 == 3'd5) && inst[30], 1'b0, a, imm_i);
    end
    OPC_OP_32: begin
      legal = (f7 == 7'h00 && (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5)) ||
              (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      exp_data = model_arith(f3, f7[5], 1'b1, a, b);
    end
    OPC_OP_IMM_32: begin
      legal = (f3 == 3'd0) || (f3 == 3'd1 && f7 == 7'h00) ||
              (f3 == 3'd5 && (f7 == 7'h00 || f7 == 7'h20));
      exp_data = model_arith(f3, (f3 == 3'd5) && inst[30], 1'b1, a, imm_i);
    end
    OPC_LUI: begin
      legal    = 1'b1;
      exp_data = imm_u;
    end
    OPC_AUIPC: begin
      legal    = 1'b1;
      exp_data = m_pc + imm_u;
    end
    OPC_JAL: begin
      legal       = 1'b1;
      exp_data    = m_pc + 64'd4;
      exp_next_pc = m_pc + imm_j;
    end
    OPC_JALR: begin
      legal       = (f3 == 3'd0);
      exp_data    = m_pc + 64'd4;
      exp_next_pc = (a + imm_i) & ~64'd1;
    end
    OPC_BRANCH: begin
      legal  = (f3 != 3'd2) && (f3 != 3'd3);
      exp_we = 1'b0;
      case (f3)
        3'd0: taken = (a == b);
        3'd1: taken = (a != b);
        3'd4: taken = ($signed(a) < $signed(b));
        3'd5: taken = ($signed(a) >= $signed(b));
        3'd6: taken = (a < b);
        3'd7: taken = (a >= b);
        default: taken = 1'b0;
      endcase
      if (taken) begin
        exp_next_pc = m_pc + imm_b;
      end
    end
    default: legal = 1'b0;
  endcase
  // unimplemented encodings act as a plain pc + 4
  if (!legal) begin
    exp_we      = 1'b0;
    exp_next_pc = m_pc + 64'd4;
  end
  exp_illegal = !legal;
endtask

// retire the evaluated instruction into the model
task automatic model_commit();
  if (exp_we && exp_rd != 5'd0) begin
    m_regs[exp_rd] = exp_data;
  end
  m_pc = exp_next_pc;
endtask

`endif

// ==== test/rv_core_tb.sv ====
module rv_core_tb;
  import rv_core_pkg::*;

  localparam logic [63:0] RESET_PC     = 64'h8000_0000;
  localparam int          RESET_CYCLES = 16;
  localparam int          N_INST       = 2000;
  // about one idle cycle in eight, plus margin
  localparam int          MAX_CYCLES   = N_INST * 5 / 4;

  logic        clk;
  logic        rst;
  logic        inst_valid;
  logic [31:0] inst;
  logic [63:0] pc;
  logic        wb_we;
  logic [4:0]  wb_addr;
  logic [63:0] wb_data;
  logic        illegal;

  int seed;
  int n_inst;
  int cycle_count;

  `include "rv_core_model.svh"

  rv_core_top #(
    .RESET_PC (RESET_PC)
  ) dut0 (
    .clk_i        (clk),
    .rst_i        (rst),
    .inst_valid_i (inst_valid),
    .inst_i       (inst),
    .pc_o         (pc),
    .wb_we_o      (wb_we),
    .wb_addr_o    (wb_addr),
    .wb_data_o    (wb_data),
    .illegal_o    (illegal)
  );

  bind rv_core_top rv_core_chk chk0 (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .inst_valid_i (inst_valid_i),
    .wb_we_o      (wb_we_o),
    .illegal_o    (illegal_o),
    .pc_o         (pc_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ==============================
  // helpers
  // ==============================

  task automatic check_value(input string test, input string what,
                             input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("mismatch %s %s: expected %h, actual %h", test, what, exp, act);
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
  endtask

  function automatic string class_name(input logic [31:0] word);
    case (word[6:0])
      OPC_OP:        return "op";
      OPC_OP_IMM:    return "op_imm";
      OPC_OP_32:     return "op_32";
      OPC_OP_IMM_32: return "op_imm_32";
      OPC_LUI:       return "lui";
      OPC_AUIPC:     return "auipc";
      OPC_JAL:       return "jal";
      OPC_JALR:      return "jalr";
      OPC_BRANCH:    return "branch";
      default:       return "unimplemented";
    endcase
  endfunction

  // random encoding, mostly legal
  function automatic logic [31:0] random_inst();
    logic [31:0] r;
    logic [31:0] s;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm12;
    r     = $random(seed);
    s     = $random(seed);
    rd    = r[4:0];
    rs1   = r[9:5];
    rs2   = r[14:10];
    f3    = r[17:15];
    f7    = 7'h00;
    imm12 = s[31:20];
    case (r[21:18])
      4'd0, 4'd1, 4'd2: begin
        if ((f3 == 3'd0 || f3 == 3'd5) && s[0]) begin
          f7 = 7'h20;
        end
        return {f7, rs2, rs1, f3, rd, OPC_OP};
      end
      4'd3, 4'd4, 4'd5: begin
        if (f3 == 3'd1) begin
          imm12[11:6] = 6'h00;
        end else if (f3 == 3'd5) begin
          imm12[11:6] = s[0] ? 6'h10 : 6'h00;
        end
        return {imm12, rs1, f3, rd, OPC_OP_IMM};
      end
      4'd6, 4'd7, 4'd8, 4'd9: begin
        // word forms only exist for funct3 0, 1 and 5
        f3 = (s[1:0] == 2'd0) ? 3'd0 : ((s[1:0] == 2'd1) ? 3'd1 : 3'd5);
        if (f3 != 3'd1 && s[2]) begin
          f7 = 7'h20;
        end
        if (r[21:18] < 4'd8) begin
          return {f7, rs2, rs1, f3, rd, OPC_OP_32};
        end
        if (f3 != 3'd0) begin
          imm12 = {f7, s[24:20]};
        end
        return {imm12, rs1, f3, rd, OPC_OP_IMM_32};
      end
      4'd10: return {s[31:12], rd, OPC_LUI};
      4'd11: return {s[31:12], rd, OPC_AUIPC};
      4'd12: return {s[31:12], rd, OPC_JAL};
      4'd13: return {imm12, rs1, 3'b000, rd, OPC_JALR};
      4'd14: begin
        if (f3[2:1] == 2'b01) begin
          f3 = {1'b1, f3[1:0]};
        end
        return {s[31:25], rs2, rs1, f3, s[11:7], OPC_BRANCH};
      end
      default: begin
        // load, mul, word shift with shamt[5], branch funct3 2
        case (s[1:0])
          2'd0:    return {s[31:7], 7'b0000011};
          2'd1:    return {7'h01, rs2, rs1, f3, rd, OPC_OP};
          2'd2:    return {7'h01, s[24:20], rs1, 3'b001, rd, OPC_OP_IMM_32};
          default: return {s[31:25], rs2, rs1, 3'b010, s[11:7], OPC_BRANCH};
        endcase
      end
    endcase
  endfunction

  task automatic check_cycle();
    string name;
    if (inst_valid) begin
      name = class_name(inst);
    end else begin
      name = "idle";
    end
    check_value(name, "pc_o", m_pc, pc);
    if (inst_valid) begin
      model_eval(inst);
      check_value(name, "illegal_o", 64'(exp_illegal), 64'(illegal));
      check_value(name, "wb_we_o", 64'(exp_we), 64'(wb_we));
      if (exp_we) begin
        check_value(name, "wb_addr_o", 64'(exp_rd), 64'(wb_addr));
        check_value(name, "wb_data_o", exp_data, wb_data);
      end
    end else begin
      check_value(name, "wb_we_o", 64'd0, 64'(wb_we));
      check_value(name, "illegal_o", 64'd0, 64'(illegal));
    end
  endtask

  // ==============================
  // main sequence
  // ==============================

  initial begin
    logic [31:0] r;
    seed       = 32'h1153_1b6a;
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst       = 32'd0;
    n_inst     = 0;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = 64'd0;
    end
    m_pc = RESET_PC;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_cycle();
    while (n_inst < N_INST) begin
      @(posedge clk);
      #1;
      r          = $random(seed);
      inst_valid = (r[2:0] != 3'd0);
      inst       = random_inst();
      @(negedge clk);
      check_cycle();
      if (inst_valid) begin
        model_commit();
        n_inst++;
      end
    end
    // last instruction must have moved the pc
    @(posedge clk);
    #1;
    inst_valid = 1'b0;
    @(negedge clk);
    check_cycle();
    $display("TEST RESULT: PASS");
    $finish;
  end

  // run limit
  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles with %0d of %0d instructions done",
             cycle_count, n_inst, N_INST);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  end

endmodule

// ==== test/rv_core_chk.sv ====
module rv_core_chk (
  input logic                         clk_i,
  input logic                         rst_i,
  input logic                         inst_valid_i,
  input logic                         wb_we_o,
  input logic                         illegal_o,
  input logic [rv_core_pkg::XLEN-1:0] pc_o
);

  // ==============================
  // writeback and flag rules
  // ==============================

  // a write is only reported for a valid instruction
  a_we_needs_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_we_o |-> inst_valid_i)
    else $error("writeback enable high while no instruction is valid");

  a_illegal_no_we: assert property (@(posedge clk_i) disable iff (rst_i)
    illegal_o |-> !wb_we_o)
    else $error("illegal instruction reported a register write");

  // targets always have bit 0 cleared
  a_pc_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
    !pc_o[0])
    else $error("program counter has bit 0 set");

endmodule

// ==== verilog/rv_core_top.sv ====
module rv_core_top #(
  parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = 64'h8000_0000
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         inst_valid_i,
  input  logic [31:0]                  inst_i,
  output logic [rv_core_pkg::XLEN-1:0] pc_o,
  output logic                         wb_we_o,
  output logic [4:0]                   wb_addr_o,
  output logic [rv_core_pkg::XLEN-1:0] wb_data_o,
  output logic                         illegal_o
);
  import rv_core_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic [4:0]      rs1_addr;
  logic [4:0]      rs2_addr;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [4:0]      rd_addr;
  logic            rd_we;
  alu_op_e         alu_op;
  logic            alu_word;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic            jump;
  logic [XLEN-1:0] target;
  logic            dec_illegal;
  logic [XLEN-1:0] alu_result;

  // ==============================
  // program counter
  // ==============================

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q <= RESET_PC;
    end else if (inst_valid_i) begin
      pc_q <= jump ? target : pc_q + XLEN'(4);
    end
  end

  assign pc_o = pc_q;

  // valid gating lives only here
  assign wb_we_o   = rd_we && inst_valid_i;
  assign wb_addr_o = rd_addr;
  assign wb_data_o = alu_result;
  assign illegal_o = dec_illegal && inst_valid_i;

  // ==============================
  // datapath
  // ==============================

  rv_decoder u_decoder (
    .inst_i     (inst_i),
    .pc_i       (pc_q),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .rs1_addr_o (rs1_addr),
    .rs2_addr_o (rs2_addr),
    .rd_addr_o  (rd_addr),
    .rd_we_o    (rd_we),
    .alu_op_o   (alu_op),
    .alu_word_o (alu_word),
    .op_a_o     (op_a),
    .op_b_o     (op_b),
    .jump_o     (jump),
    .target_o   (target),
    .illegal_o  (dec_illegal)
  );

  // register file beside the alu it feeds
  rv_regfile u_regfile (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .we_i       (wb_we_o),
    .rd_addr_i  (rd_addr),
    .rd_data_i  (alu_result),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  rv_alu u_alu (
    .alu_op_i   (alu_op),
    .alu_word_i (alu_word),
    .op_a_i     (op_a),
    .op_b_i     (op_b),
    .result_o   (alu_result)
  );

endmodule

// ==== verilog/rv_regfile.sv ====
module rv_regfile (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic [4:0]                   rs1_addr_i,
  input  logic [4:0]                   rs2_addr_i,
  input  logic                         we_i,
  input  logic [4:0]                   rd_addr_i,
  input  logic [rv_core_pkg::XLEN-1:0] rd_data_i,
  output logic [rv_core_pkg::XLEN-1:0] rs1_data_o,
  output logic [rv_core_pkg::XLEN-1:0] rs2_data_o
);
  import rv_core_pkg::*;

  // x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  // ==============================
  // write port
  // ==============================

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && rd_addr_i != 5'd0) begin
      regs[rd_addr_i] <= rd_data_i;
    end
  end

  // ==============================
  // read ports
  // ==============================

  // combinational, x0 reads zero
  assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

endmodule

// ==== verilog/rv_alu.sv ====
module rv_alu (
  input  rv_core_pkg::alu_op_e         alu_op_i,
  input  logic                         alu_word_i,
  input  logic [rv_core_pkg::XLEN-1:0] op_a_i,
  input  logic [rv_core_pkg::XLEN-1:0] op_b_i,
  output logic [rv_core_pkg::XLEN-1:0] result_o
);
  import rv_core_pkg::*;

  logic [4:0]      shamt_w;
  logic [5:0]      shamt_d;
  logic [31:0]     sll_w;
  logic [31:0]     srl_w;
  logic [31:0]     sra_w;
  logic [XLEN-1:0] sll_d;
  logic [XLEN-1:0] srl_d;
  logic [XLEN-1:0] sra_d;
  logic [XLEN-1:0] raw;

  // ==============================
  // shifters
  // ==============================

  assign shamt_w = op_b_i[4:0];
  assign shamt_d = op_b_i[5:0];

  // word shifts see only the low half of operand a
  assign sll_w = op_a_i[31:0] << shamt_w;
  assign srl_w = op_a_i[31:0] >> shamt_w;
  assign sra_w = $signed(op_a_i[31:0]) >>> shamt_w;

  assign sll_d = op_a_i << shamt_d;
  assign srl_d = op_a_i >> shamt_d;
  assign sra_d = $signed(op_a_i) >>> shamt_d;

  // ==============================
  // operation select
  // ==============================

  always_comb begin
    case (alu_op_i)
      ALU_ADD:    raw = op_a_i + op_b_i;
      ALU_SUB:    raw = op_a_i - op_b_i;
      ALU_SLT:    raw = {{(XLEN-1){1'b0}}, $signed(op_a_i) < $signed(op_b_i)};
      ALU_SLTU:   raw = {{(XLEN-1){1'b0}}, op_a_i < op_b_i};
      ALU_AND:    raw = op_a_i & op_b_i;
      ALU_OR:     raw = op_a_i | op_b_i;
      ALU_XOR:    raw = op_a_i ^ op_b_i;
      ALU_SLL:    raw = alu_word_i ? {{(XLEN-32){1'b0}}, sll_w} : sll_d;
      ALU_SRL:    raw = alu_word_i ? {{(XLEN-32){1'b0}}, srl_w} : srl_d;
      ALU_SRA:    raw = alu_word_i ? {{(XLEN-32){1'b0}}, sra_w} : sra_d;
      ALU_PASS_B: raw = op_b_i;
      default:    raw = '0;
    endcase
  end

  // word results are sign extended from bit 31
  assign result_o = alu_word_i ? {{(XLEN-32){raw[31]}}, raw[31:0]} : raw;

endmodule

// ==== verilog/rv_decoder.sv ====
module rv_decoder (
  input  logic [31:0]                  inst_i,
  input  logic [rv_core_pkg::XLEN-1:0] pc_i,
  input  logic [rv_core_pkg::XLEN-1:0] rs1_data_i,
  input  logic [rv_core_pkg::XLEN-1:0] rs2_data_i,
  output logic [4:0]                   rs1_addr_o,
  output logic [4:0]                   rs2_addr_o,
  output logic [4:0]                   rd_addr_o,
  output logic                         rd_we_o,
  output rv_core_pkg::alu_op_e         alu_op_o,
  output logic                         alu_word_o,
  output logic [rv_core_pkg::XLEN-1:0] op_a_o,
  output logic [rv_core_pkg::XLEN-1:0] op_b_o,
  output logic                         jump_o,
  output logic [rv_core_pkg::XLEN-1:0] target_o,
  output logic                         illegal_o
);
  import rv_core_pkg::*;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            f7_zero;
  logic            f7_alt;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm;

  logic            op_ok;
  logic            op_imm_ok;
  logic            op_32_ok;
  logic            op_imm_32_ok;
  logic            legal;

  logic            br_eq;
  logic            br_lt;
  logic            br_ltu;
  logic            br_taken;

  alu_op_e         func_op;
  logic            sel_pc;
  logic            sel_imm;
  logic            sel_four;
  logic            rd_we;
  logic            jump;
  logic [XLEN-1:0] jalr_sum;

  // ==============================
  // instruction fields
  // ==============================

  assign opcode     = inst_i[6:0];
  assign funct3     = inst_i[14:12];
  assign funct7     = inst_i[31:25];
  assign rd_addr_o  = inst_i[11:7];
  assign rs1_addr_o = inst_i[19:15];
  assign rs2_addr_o = inst_i[24:20];

  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);

  // sign extended immediates
  assign imm_i = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};
  assign imm_u = {{(XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_j = {{(XLEN-21){inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                  inst_i[30:21], 1'b0};
  assign imm_b = {{(XLEN-13){inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                  inst_i[11:8], 1'b0};

  // ==============================
  // encoding checks per class
  // ==============================

  // only add/sub and srl/sra have an alternate funct7
  assign op_ok = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));

  // bits 31:26 hold the shift type, bit 25 is shamt[5]
  assign op_imm_ok = (funct3 == 3'b001) ? (inst_i[31:26] == 6'b000000) :
                     (funct3 == 3'b101) ? (inst_i[31:26] == 6'b000000 ||
                                           inst_i[31:26] == 6'b010000) :
                     1'b1;

  assign op_32_ok = (funct3 == 3'b000 || funct3 == 3'b101) ? (f7_zero || f7_alt) :
                    (funct3 == 3'b001) ? f7_zero :
                    1'b0;

  // word shifts with shamt[5] set fail the funct7 check
  assign op_imm_32_ok = (funct3 == 3'b000) ? 1'b1 :
                        (funct3 == 3'b001) ? f7_zero :
                        (funct3 == 3'b101) ? (f7_zero || f7_alt) :
                        1'b0;

  // ==============================
  // branch resolution
  // ==============================

  assign br_eq  = (rs1_data_i == rs2_data_i);
  assign br_lt  = ($signed(rs1_data_i) < $signed(rs2_data_i));
  assign br_ltu = (rs1_data_i < rs2_data_i);

  always_comb begin
    case (funct3)
      3'b000:  br_taken = br_eq;
      3'b001:  br_taken = !br_eq;
      3'b100:  br_taken = br_lt;
      3'b101:  br_taken = !br_lt;
      3'b110:  br_taken = br_ltu;
      3'b111:  br_taken = !br_ltu;
      default: br_taken = 1'b0;
    endcase
  end

  // alu operation from funct3, shared by all four arithmetic classes
  always_comb begin
    case (funct3)
      3'b000:  func_op = ((opcode == OPC_OP || opcode == OPC_OP_32) && funct7[5]) ?
                         ALU_SUB : ALU_ADD;
      3'b001:  func_op = ALU_SLL;
      3'b010:  func_op = ALU_SLT;
      3'b011:  func_op = ALU_SLTU;
      3'b100:  func_op = ALU_XOR;
      3'b101:  func_op = funct7[5] ? ALU_SRA : ALU_SRL;
      3'b110:  func_op = ALU_OR;
      default: func_op = ALU_AND;
    endcase
  end

  // ==============================
  // main decode
  // ==============================

  always_comb begin
    alu_op_o   = ALU_ADD;
    alu_word_o = 1'b0;
    sel_pc     = 1'b0;
    sel_imm    = 1'b0;
    sel_four   = 1'b0;
    imm        = imm_i;
    rd_we      = 1'b0;
    jump       = 1'b0;
    legal      = 1'b0;
    case (opcode)
      OPC_OP: begin
        alu_op_o = func_op;
        rd_we    = 1'b1;
        legal    = op_ok;
      end
      OPC_OP_IMM: begin
        alu_op_o = func_op;
        sel_imm  = 1'b1;
        rd_we    = 1'b1;
        legal    = op_imm_ok;
      end
      OPC_OP_32: begin
        alu_op_o   = func_op;
        alu_word_o = 1'b1;
        rd_we      = 1'b1;
        legal      = op_32_ok;
      end
      OPC_OP_IMM_32: begin
        alu_op_o   = func_op;
        alu_word_o = 1'b1;
        sel_imm    = 1'b1;
        rd_we      = 1'b1;
        legal      = op_imm_32_ok;
      end
      OPC_LUI: begin
        alu_op_o = ALU_PASS_B;
        imm      = imm_u;
        sel_imm  = 1'b1;
        rd_we    = 1'b1;
        legal    = 1'b1;
      end
      OPC_AUIPC: begin
        imm     = imm_u;
        sel_pc  = 1'b1;
        sel_imm = 1'b1;
        rd_we   = 1'b1;
        legal   = 1'b1;
      end
      // link value is pc + 4 through the alu adder
      OPC_JAL: begin
        imm      = imm_j;
        sel_pc   = 1'b1;
        sel_four = 1'b1;
        rd_we    = 1'b1;
        jump     = 1'b1;
        legal    = 1'b1;
      end
      OPC_JALR: begin
        sel_pc   = 1'b1;
        sel_four = 1'b1;
        rd_we    = 1'b1;
        jump     = 1'b1;
        legal    = (funct3 == 3'b000);
      end
      OPC_BRANCH: begin
        imm   = imm_b;
        jump  = br_taken;
        legal = (funct3[2:1] != 2'b01);
      end
      default: begin
        legal = 1'b0;
      end
    endcase
  end

  // ==============================
  // operands and next pc
  // ==============================

  assign op_a_o = sel_pc ? pc_i : rs1_data_i;
  assign op_b_o = sel_four ? XLEN'(4) : (sel_imm ? imm : rs2_data_i);

  assign jalr_sum = rs1_data_i + imm_i;
  assign target_o = (opcode == OPC_JALR) ? {jalr_sum[XLEN-1:1], 1'b0} : pc_i + imm;

  // unimplemented encodings behave as a no-op
  assign rd_we_o   = rd_we && legal;
  assign jump_o    = jump && legal;
  assign illegal_o = !legal;

endmodule

// ==== verilog/rv_core_pkg.sv ====
package rv_core_pkg;

  // ==============================
  // widths
  // ==============================

  // data and address width
  localparam int XLEN = 64;

  // ==============================
  // major opcodes
  // ==============================

  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH    = 7'b1100011;

  // ==============================
  // alu operations
  // ==============================

  // word form is a separate flag, not encoded here
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_SLTU,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    // forwards operand b, used by lui
    ALU_PASS_B
  } alu_op_e;

endpackage
